// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = membus_soc_tb
FILELIST  = membus_soc.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/data_mem.sv ====
`default_nettype none

module data_mem
   import membus_pkg::*;
#(
   parameter int WIDTH = 8
) (
   input  wire logic             clk,
   input  wire logic [WIDTH-1:0] addr_i,
   input  wire bus_cmd_t         cmd_i,
   output bus_result_t           result_o
);

   localparam int DEPTH = 2 ** WIDTH;

   logic [31:0] mem [DEPTH];
   logic [31:0] read_q;

   // Byte lanes written under mask
   always_ff @(posedge clk) begin
      if (cmd_i.mem_write) begin
         for (int i = 0; i < 4; i++) begin
            if (cmd_i.mask_byte[i]) begin
               mem[addr_i][8*i +: 8] <= cmd_i.write_data[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_i.mem_read) begin
         read_q <= mem[addr_i];
      end
   end

   assign result_o.read_data = read_q;
   assign result_o.error     = 1'b0;

endmodule

`default_nettype wire

// ==== hw/mem_controller.sv ====
`default_nettype none

module mem_controller
   import membus_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset_i,
   input  wire logic        req_valid_i,
   input  wire core_req_t   req_i,
   output logic             req_ready_o,
   output logic [29:0]      bus_addr_o,
   output bus_cmd_t         bus_cmd_o,
   input  wire bus_result_t bus_result_i,
   input  wire logic        bus_stall_i,
   output logic             rsp_valid_o,
   output core_rsp_t        rsp_o
);

   logic        accept;
   logic        is_store;
   logic        misaligned;
   logic [1:0]  offset;
   logic [3:0]  lane_mask;

   mem_inst_e   inst_q;
   logic [1:0]  offset_q;
   logic        misaligned_q;
   logic [31:0] shifted;
   logic [31:0] load_data;

   assign offset      = req_i.addr[1:0];
   assign req_ready_o = !bus_stall_i;
   assign accept      = req_valid_i && req_ready_o;
   assign bus_addr_o  = req_i.addr[31:2];

   always_comb begin
      is_store   = 1'b0;
      misaligned = 1'b0;
      lane_mask  = 4'b0000;
      case (req_i.inst)
         MEM_LH, MEM_LHU: misaligned = offset[0];
         MEM_LW:          misaligned = (offset != 2'd0);
         MEM_SB: begin
            is_store  = 1'b1;
            lane_mask = 4'b0001 << offset;
         end
         MEM_SH: begin
            is_store   = 1'b1;
            misaligned = offset[0];
            lane_mask  = 4'b0011 << offset;
         end
         MEM_SW: begin
            is_store   = 1'b1;
            misaligned = (offset != 2'd0);
            lane_mask  = 4'b1111;
         end
         default: ;
      endcase
   end

   // Mask stays zero for loads, so a non-zero mask marks a pending store
   always_comb begin
      bus_cmd_o.write_data = req_i.wdata << {offset, 3'b000};
      bus_cmd_o.mask_byte  = misaligned ? 4'b0000 : lane_mask;
      bus_cmd_o.mem_read   = accept && !is_store && !misaligned;
      bus_cmd_o.mem_write  = accept && is_store && !misaligned;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         inst_q       <= req_i.inst;
         offset_q     <= offset;
         misaligned_q <= misaligned;
      end
   end

   // Load formatting in the response cycle
   always_comb begin
      shifted = bus_result_i.read_data >> {offset_q, 3'b000};
      case (inst_q)
         MEM_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
         MEM_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
         MEM_LW:  load_data = shifted;
         MEM_LBU: load_data = {24'h0, shifted[7:0]};
         MEM_LHU: load_data = {16'h0, shifted[15:0]};
         default: load_data = 32'h0;
      endcase
   end

   always_comb begin
      rsp_o = '0;
      if (misaligned_q) begin
         rsp_o.misaligned = 1'b1;
      end else if (bus_result_i.error) begin
         rsp_o.bus_error = 1'b1;
      end else begin
         rsp_o.rdata = load_data;
      end
   end

   a_rsp_follows_accept: assert property (
      @(posedge clk) disable iff (reset_i) accept |=> rsp_valid_o);

endmodule

`default_nettype wire

// ==== hw/membus_defs.svh ====
`ifndef MEMBUS_DEFS_SVH
`define MEMBUS_DEFS_SVH

// RAM word-address bits, RAM sits at word base 0
`define RAM_WIDTH 8

// UART window, in words
`define UART_BASE 'h100
`define UART_SIZE 4

// Serial bit period in clocks
`define UART_CLKS_PER_BIT 4

`endif

// ==== hw/membus_pkg.sv ====
`default_nettype none

package membus_pkg;

   // Load/store access type
   typedef enum logic [2:0] {
      MEM_LB,
      MEM_LH,
      MEM_LW,
      MEM_LBU,
      MEM_LHU,
      MEM_SB,
      MEM_SH,
      MEM_SW
   } mem_inst_e;

   // Request from the core
   typedef struct packed {
      mem_inst_e   inst;
      logic [31:0] addr;
      logic [31:0] wdata;
   } core_req_t;

   // Response to the core
   typedef struct packed {
      logic [31:0] rdata;
      logic        misaligned;
      logic        bus_error;
   } core_rsp_t;

   // Command on the slave bus, data already in its lanes
   typedef struct packed {
      logic [31:0] write_data;
      logic [3:0]  mask_byte;
      logic        mem_read;
      logic        mem_write;
   } bus_cmd_t;

   typedef struct packed {
      logic [31:0] read_data;
      logic        error;
   } bus_result_t;

   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_e;

endpackage

`default_nettype wire

// ==== hw/membus_soc.sv ====
`default_nettype none

`include "membus_defs.svh"

module membus_soc
   import membus_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset_i,
   input  wire logic      req_valid_i,
   output logic           req_ready_o,
   input  wire core_req_t req_i,
   output logic           rsp_valid_o,
   output core_rsp_t      rsp_o,
   output logic           uart_tx_o
);

   logic [29:0] cpu_addr;
   bus_cmd_t    cpu_cmd;
   bus_result_t cpu_result;
   logic        cpu_stall;

   logic [29:0] ram_addr;
   bus_cmd_t    ram_cmd;
   bus_result_t ram_result;

   logic [29:0] uart_addr;
   bus_cmd_t    uart_cmd;
   bus_result_t uart_result;
   logic        uart_busy;

   mem_controller u_ctrl (
      .clk          (clk),
      .reset_i      (reset_i),
      .req_valid_i  (req_valid_i),
      .req_i        (req_i),
      .req_ready_o  (req_ready_o),
      .bus_addr_o   (cpu_addr),
      .bus_cmd_o    (cpu_cmd),
      .bus_result_i (cpu_result),
      .bus_stall_i  (cpu_stall),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_o        (rsp_o)
   );

   // RAM never stalls
   slave_bus_mux #(
      .BASE1 (30'h0),
      .SIZE1 (30'(2 ** `RAM_WIDTH)),
      .BASE2 (30'(`UART_BASE)),
      .SIZE2 (30'(`UART_SIZE))
   ) u_mux (
      .clk        (clk),
      .reset_i    (reset_i),
      .addr_i     (cpu_addr),
      .cmd_i      (cpu_cmd),
      .result_o   (cpu_result),
      .stall_o    (cpu_stall),
      .addr_1_o   (ram_addr),
      .cmd_1_o    (ram_cmd),
      .result_1_i (ram_result),
      .busy_1_i   (1'b0),
      .addr_2_o   (uart_addr),
      .cmd_2_o    (uart_cmd),
      .result_2_i (uart_result),
      .busy_2_i   (uart_busy)
   );

   data_mem #(.WIDTH(`RAM_WIDTH)) u_ram (
      .clk      (clk),
      .addr_i   (ram_addr[`RAM_WIDTH-1:0]),
      .cmd_i    (ram_cmd),
      .result_o (ram_result)
   );

   uart_tx #(.CLKS_PER_BIT(`UART_CLKS_PER_BIT)) u_uart (
      .clk      (clk),
      .reset_i  (reset_i),
      .addr_i   (uart_addr[1:0]),
      .cmd_i    (uart_cmd),
      .result_o (uart_result),
      .busy_o   (uart_busy),
      .tx_o     (uart_tx_o)
   );

endmodule

`default_nettype wire

// ==== hw/slave_bus_mux.sv ====
`default_nettype none

module slave_bus_mux
   import membus_pkg::*;
#(
   parameter logic [29:0] BASE1 = 30'h0,
   parameter logic [29:0] SIZE1 = 30'h100,
   parameter logic [29:0] BASE2 = 30'h100,
   parameter logic [29:0] SIZE2 = 30'h4
) (
   input  wire logic        clk,
   input  wire logic        reset_i,
   input  wire logic [29:0] addr_i,
   input  wire bus_cmd_t    cmd_i,
   output bus_result_t      result_o,
   output logic             stall_o,
   output logic [29:0]      addr_1_o,
   output bus_cmd_t         cmd_1_o,
   input  wire bus_result_t result_1_i,
   input  wire logic        busy_1_i,
   output logic [29:0]      addr_2_o,
   output bus_cmd_t         cmd_2_o,
   input  wire bus_result_t result_2_i,
   input  wire logic        busy_2_i
);

   logic       in_win1;
   logic       in_win2;
   logic       store_pending;
   logic [1:0] sel_q;

   // Window offsets, wraparound makes one compare enough
   assign addr_1_o = addr_i - BASE1;
   assign addr_2_o = addr_i - BASE2;
   assign in_win1  = (addr_1_o < SIZE1);
   assign in_win2  = (addr_2_o < SIZE2);

   always_comb begin
      cmd_1_o = cmd_i;
      cmd_2_o = cmd_i;
      if (!in_win1) begin
         cmd_1_o.mem_read  = 1'b0;
         cmd_1_o.mem_write = 1'b0;
      end
      if (!in_win2) begin
         cmd_2_o.mem_read  = 1'b0;
         cmd_2_o.mem_write = 1'b0;
      end
   end

   assign store_pending = (cmd_i.mask_byte != 4'b0000);
   assign stall_o = (busy_1_i && in_win1 && store_pending) ||
                    (busy_2_i && in_win2 && store_pending);

   // Bit 0 selects slave 1, bit 1 slave 2, zero means unmapped
   always_ff @(posedge clk) begin
      if (reset_i) begin
         sel_q <= 2'b00;
      end else if (cmd_i.mem_read || cmd_i.mem_write) begin
         sel_q <= {in_win2, in_win1};
      end
   end

   always_comb begin
      case (sel_q)
         2'b01:   result_o = result_1_i;
         2'b10:   result_o = result_2_i;
         default: result_o = '{read_data: 32'h0, error: 1'b1};
      endcase
   end

   a_one_slave: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0({cmd_1_o.mem_read || cmd_1_o.mem_write,
                cmd_2_o.mem_read || cmd_2_o.mem_write}));

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`default_nettype none

module uart_tx
   import membus_pkg::*;
#(
   parameter int CLKS_PER_BIT = 4
) (
   input  wire logic       clk,
   input  wire logic       reset_i,
   input  wire logic [1:0] addr_i,
   input  wire bus_cmd_t   cmd_i,
   output bus_result_t     result_o,
   output logic            busy_o,
   output logic            tx_o
);

   localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CW-1:0] LAST_CLK = CW'(CLKS_PER_BIT - 1);

   uart_state_e state_q;
   logic [CW-1:0] clk_cnt_q;
   logic [2:0]    bit_idx_q;
   logic [7:0]    shift_q;
   logic          tx_q;
   logic [31:0]   read_q;
   logic          busy;
   logic          start;
   logic          bit_end;

   assign busy    = (state_q != UART_IDLE);
   assign start   = cmd_i.mem_write && (addr_i == 2'd0) && cmd_i.mask_byte[0] && !busy;
   assign bit_end = (clk_cnt_q == LAST_CLK);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q   <= UART_IDLE;
         clk_cnt_q <= '0;
         bit_idx_q <= 3'd0;
         tx_q      <= 1'b1;
      end else begin
         clk_cnt_q <= (busy && !bit_end) ? clk_cnt_q + 1'b1 : '0;
         case (state_q)
            UART_IDLE: begin
               if (start) begin
                  state_q <= UART_START;
                  tx_q    <= 1'b0;
               end
            end
            UART_START: begin
               if (bit_end) begin
                  state_q   <= UART_DATA;
                  bit_idx_q <= 3'd0;
                  tx_q      <= shift_q[0];
               end
            end
            UART_DATA: begin
               if (bit_end) begin
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == 3'd7) begin
                     state_q <= UART_STOP;
                     tx_q    <= 1'b1;
                  end else begin
                     tx_q <= shift_q[1];
                  end
               end
            end
            UART_STOP: begin
               if (bit_end) begin
                  state_q <= UART_IDLE;
               end
            end
            default: state_q <= UART_IDLE;
         endcase
      end
   end

   // LSB first, so shift right after each data bit
   always_ff @(posedge clk) begin
      if (start) begin
         shift_q <= cmd_i.write_data[7:0];
      end else if (state_q == UART_DATA && bit_end) begin
         shift_q <= shift_q >> 1;
      end
   end

   // Status word holds busy in bit 0
   always_ff @(posedge clk) begin
      if (cmd_i.mem_read) begin
         read_q <= (addr_i == 2'd0) ? {31'h0, busy} : 32'h0;
      end
   end

   assign result_o.read_data = read_q;
   assign result_o.error     = 1'b0;
   assign busy_o             = busy;
   assign tx_o               = tx_q;

   a_no_write_busy: assert property (
      @(posedge clk) disable iff (reset_i) cmd_i.mem_write |-> !busy);

endmodule

`default_nettype wire

// ==== membus_soc.f ====
+incdir+hw
hw/membus_pkg.sv
hw/mem_controller.sv
hw/slave_bus_mux.sv
hw/data_mem.sv
hw/uart_tx.sv
hw/membus_soc.sv
verif/membus_soc_tb.sv

// ==== verif/membus_soc_tb.sv ====
`default_nettype none

`include "membus_defs.svh"

module membus_soc_tb
   import membus_pkg::*;
();

   localparam int PERIOD       = 40;
   localparam int RESET_CYCLES = 8;
   localparam int RAM_WORDS    = 2 ** `RAM_WIDTH;
   localparam int NUM_RANDOM   = 200;
   // Fill, directed and random requests, rounded up
   localparam int NUM_REQUESTS = RAM_WORDS + NUM_RANDOM + 150;
   localparam int FRAME_TIME   = 10 * `UART_CLKS_PER_BIT * PERIOD;
   localparam int TIME_LIMIT   = NUM_REQUESTS * FRAME_TIME + 100 * PERIOD;
   localparam logic [31:0] UART_ADDR = 32'(`UART_BASE) << 2;

   logic      clk;
   logic      reset_i;
   logic      req_valid_i;
   logic      req_ready_o;
   core_req_t req_i;
   logic      rsp_valid_o;
   core_rsp_t rsp_o;
   logic      uart_tx_o;

   logic [7:0] shadow [4*RAM_WORDS];
   time        uart_busy_until;
   core_rsp_t  exp_rsp_q [$];
   logic [7:0] exp_byte_q [$];
   int         rsp_errors;
   int         uart_errors;
   int         misc_errors;
   int         seed;

   membus_soc dut (
      .clk         (clk),
      .reset_i     (reset_i),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .req_i       (req_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o),
      .uart_tx_o   (uart_tx_o)
   );

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   function automatic core_req_t make_req(input mem_inst_e inst, input logic [31:0] addr,
                                          input logic [31:0] wdata);
      core_req_t req;
      req.inst  = inst;
      req.addr  = addr;
      req.wdata = wdata;
      return req;
   endfunction

   function automatic int access_bytes(input mem_inst_e inst);
      case (inst)
         MEM_LB, MEM_LBU, MEM_SB: return 1;
         MEM_LH, MEM_LHU, MEM_SH: return 2;
         default:                 return 4;
      endcase
   endfunction

   function automatic logic is_store(input mem_inst_e inst);
      return inst inside {MEM_SB, MEM_SH, MEM_SW};
   endfunction

   function automatic logic is_misaligned(input core_req_t req);
      case (req.inst)
         MEM_LH, MEM_LHU, MEM_SH: return req.addr[0];
         MEM_LW, MEM_SW:          return req.addr[1:0] != 2'b00;
         default:                 return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] fill_word(input int i);
      return (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
   endfunction

   function automatic logic [7:0] model_byte(input logic [31:0] addr, input time t);
      logic [31:0] status;
      status = 32'h0;
      if (addr[31:2] < 30'(RAM_WORDS)) begin
         return shadow[int'(addr[`RAM_WIDTH+1:0])];
      end
      // Only the UART status word reads non-zero
      if (addr[31:2] == 30'(`UART_BASE) && t <= uart_busy_until) begin
         status = 32'h1;
      end
      return status[8*addr[1:0] +: 8];
   endfunction

   function automatic core_rsp_t expected_rsp(input core_req_t req, input time t);
      core_rsp_t   rsp;
      logic [29:0] word;
      logic [7:0]  b [4];
      logic        mapped;
      rsp    = '0;
      word   = req.addr[31:2];
      mapped = (word < 30'(RAM_WORDS)) ||
               (word >= 30'(`UART_BASE) && word < 30'(`UART_BASE + `UART_SIZE));
      for (int i = 0; i < 4; i++) begin
         b[i] = (i < access_bytes(req.inst)) ? model_byte(req.addr + 32'(i), t) : 8'h00;
      end
      if (is_misaligned(req)) begin
         rsp.misaligned = 1'b1;
      end else if (!mapped) begin
         rsp.bus_error = 1'b1;
      end else begin
         case (req.inst)
            MEM_LB:  rsp.rdata = {{24{b[0][7]}}, b[0]};
            MEM_LBU: rsp.rdata = {24'h0, b[0]};
            MEM_LH:  rsp.rdata = {{16{b[1][7]}}, b[1], b[0]};
            MEM_LHU: rsp.rdata = {16'h0, b[1], b[0]};
            MEM_LW:  rsp.rdata = {b[3], b[2], b[1], b[0]};
            default: rsp.rdata = 32'h0;
         endcase
      end
      return rsp;
   endfunction

   task automatic update_model(input core_req_t req, input time t);
      int base;
      base = int'(req.addr[`RAM_WIDTH+1:0]);
      if (is_store(req.inst) && !is_misaligned(req)) begin
         if (req.addr[31:2] < 30'(RAM_WORDS)) begin
            for (int i = 0; i < access_bytes(req.inst); i++) begin
               shadow[base + i] = req.wdata[8*i +: 8];
            end
         end else if (req.addr[31:2] == 30'(`UART_BASE) && req.addr[1:0] == 2'b00) begin
            exp_byte_q.push_back(req.wdata[7:0]);
            uart_busy_until = t + FRAME_TIME;
         end
      end
   endtask

   task automatic check_rsp(input core_rsp_t exp, input core_rsp_t act);
      if (act !== exp) begin
         $display("Error at time %0t: response expected rdata %h mis %b err %b, got %h %b %b",
                  $time, exp.rdata, exp.misaligned, exp.bus_error,
                  act.rdata, act.misaligned, act.bus_error);
         rsp_errors++;
      end
   endtask

   task automatic check_byte(input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("Error at time %0t: UART byte expected %h, got %h", $time, exp, act);
         uart_errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error at time %0t: %s expected %b, got %b", $time, what, exp, act);
         misc_errors++;
      end
   endtask

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic issue(input core_req_t req);
      req_i       = req;
      req_valid_i = 1'b1;
      #(PERIOD / 4);
      while (!req_ready_o) begin
         @(negedge clk);
         #(PERIOD / 4);
      end
      @(posedge clk);
      exp_rsp_q.push_back(expected_rsp(req, $time));
      update_model(req, $time);
      @(negedge clk);
      req_valid_i = 1'b0;
      check_bit("rsp_valid_o after acceptance", 1'b1, rsp_valid_o);
   endtask

   task automatic sweep_loads(input logic [31:0] base);
      for (int off = 0; off < 4; off++) begin
         issue(make_req(MEM_LB, base + 32'(off), 32'h0));
         issue(make_req(MEM_LBU, base + 32'(off), 32'h0));
      end
      for (int off = 0; off < 4; off += 2) begin
         issue(make_req(MEM_LH, base + 32'(off), 32'h0));
         issue(make_req(MEM_LHU, base + 32'(off), 32'h0));
      end
      issue(make_req(MEM_LW, base, 32'h0));
   endtask

   task automatic wait_uart_idle();
      while ($time <= uart_busy_until) begin
         @(negedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (!reset_i && rsp_valid_o) begin
         if (exp_rsp_q.size() == 0) begin
            $display("Response at time %0t arrived with no request outstanding", $time);
            misc_errors++;
         end else begin
            check_rsp(exp_rsp_q.pop_front(), rsp_o);
         end
      end
   end

   // Serial monitor, samples near each bit center
   initial begin : serial_monitor
      logic [7:0] data;
      @(negedge reset_i);
      forever begin
         @(negedge uart_tx_o);
         repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
         if (uart_tx_o !== 1'b0) begin
            $display("UART start bit did not stay low at time %0t", $time);
            misc_errors++;
         end
         for (int i = 0; i < 8; i++) begin
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            data[i] = uart_tx_o;
         end
         repeat (`UART_CLKS_PER_BIT) @(negedge clk);
         if (uart_tx_o !== 1'b1) begin
            $display("UART stop bit missing at time %0t", $time);
            misc_errors++;
         end
         if (exp_byte_q.size() == 0) begin
            $display("UART sent byte %h at time %0t that was never stored", data, $time);
            misc_errors++;
         end else begin
            check_byte(exp_byte_q.pop_front(), data);
         end
      end
   end

   initial begin : watchdog
      #(TIME_LIMIT);
      $display("Timeout: the run did not finish within %0d time units", TIME_LIMIT);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin : stimulus
      mem_inst_e   inst;
      logic [31:0] addr;
      reset_i         = 1'b1;
      req_valid_i     = 1'b0;
      req_i           = '0;
      uart_busy_until = 0;
      rsp_errors      = 0;
      uart_errors     = 0;
      misc_errors     = 0;
      seed            = 51741;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;

      // Idle state after reset
      check_bit("uart_tx_o after reset", 1'b1, uart_tx_o);
      check_bit("rsp_valid_o after reset", 1'b0, rsp_valid_o);
      issue(make_req(MEM_LW, UART_ADDR, 32'h0));

      // Fill the RAM, then partial stores and load sweeps
      for (int i = 0; i < RAM_WORDS; i++) begin
         issue(make_req(MEM_SW, 32'(i) << 2, fill_word(i)));
      end
      issue(make_req(MEM_SB, 32'h0000_001D, 32'hDEAD_BE80));
      issue(make_req(MEM_SB, 32'h0000_001F, 32'h1234_567F));
      issue(make_req(MEM_SH, 32'h0000_0022, 32'hCAFE_F00D));
      issue(make_req(MEM_SH, 32'h0000_0020, 32'h0000_7FFE));
      sweep_loads(32'h0000_001C);
      sweep_loads(32'h0000_0020);
      sweep_loads(32'h0000_03FC);

      // Misaligned accesses leave memory alone
      issue(make_req(MEM_LH, 32'h0000_0041, 32'h0));
      issue(make_req(MEM_LHU, 32'h0000_0043, 32'h0));
      issue(make_req(MEM_LW, 32'h0000_0042, 32'h0));
      issue(make_req(MEM_LW, 32'h0000_0041, 32'h0));
      issue(make_req(MEM_SH, 32'h0000_0045, 32'hFFFF_FFFF));
      issue(make_req(MEM_SW, 32'h0000_0046, 32'hFFFF_FFFF));
      sweep_loads(32'h0000_0044);

      // Unmapped addresses
      issue(make_req(MEM_LW, 32'h0000_0410, 32'h0));
      issue(make_req(MEM_LB, 32'h0000_0800, 32'h0));
      issue(make_req(MEM_SW, 32'h0000_1000, 32'h1111_2222));
      issue(make_req(MEM_LW, 32'h0000_1000, 32'h0));
      issue(make_req(MEM_LHU, 32'hFFFF_FFFE, 32'h0));
      issue(make_req(MEM_SB, 32'h7FFF_FFF0, 32'h0000_0033));
      // RAM words that the unmapped stores would alias onto
      issue(make_req(MEM_LW, 32'h0000_0000, 32'h0));
      issue(make_req(MEM_LW, 32'h0000_03F0, 32'h0));

      // UART frames, status and back-pressure
      issue(make_req(MEM_SW, UART_ADDR, 32'h0000_0055));
      issue(make_req(MEM_LW, UART_ADDR, 32'h0));
      req_i       = make_req(MEM_SB, UART_ADDR, 32'h0000_00A3);
      req_valid_i = 1'b1;
      #(PERIOD / 4);
      check_bit("req_ready_o during a UART frame", 1'b0, req_ready_o);
      @(negedge clk);
      issue(make_req(MEM_SB, UART_ADDR, 32'h0000_00A3));
      issue(make_req(MEM_SW, UART_ADDR, 32'hFFFF_FF1E));
      issue(make_req(MEM_LB, UART_ADDR, 32'h0));
      wait_uart_idle();
      issue(make_req(MEM_LW, UART_ADDR, 32'h0));
      issue(make_req(MEM_SW, UART_ADDR + 32'h8, 32'h0000_0099));
      issue(make_req(MEM_LW, UART_ADDR + 32'h8, 32'h0));
      issue(make_req(MEM_LW, UART_ADDR + 32'hC, 32'h0));

      // Random RAM traffic
      for (int n = 0; n < NUM_RANDOM; n++) begin
         inst = mem_inst_e'(3'($random(seed)));
         addr = 32'($random(seed)) & 32'h0000_00FF;
         if (($random(seed) & 3) != 0) begin
            addr = addr & ~(32'(access_bytes(inst)) - 32'd1);
         end
         issue(make_req(inst, addr, $random(seed)));
      end

      wait_uart_idle();
      repeat (4) @(negedge clk);
      if (exp_rsp_q.size() != 0) begin
         $display("%0d responses never arrived", exp_rsp_q.size());
         misc_errors += exp_rsp_q.size();
      end
      if (exp_byte_q.size() != 0) begin
         $display("%0d UART bytes were never sent", exp_byte_q.size());
         misc_errors += exp_byte_q.size();
      end
      $display("Response errors %0d, UART errors %0d, other errors %0d",
               rsp_errors, uart_errors, misc_errors);
      if (rsp_errors + uart_errors + misc_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire
